//--- Makefile
TOP := tb_sequential_alu

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f $(wildcard hdl/*.sv hdl/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "Everything OK" run.log

clean:
	rm -rf obj_dir run.log

//--- hdl/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand and result width in bits
`define ALU_WIDTH 16

// step counter width, log2 of the width plus one
`define ALU_CNT_W 5

`endif

//--- hdl/alu_control.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module alu_control (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  alu_pkg::operand_t   i_a,
   input  alu_pkg::operand_t   i_b,
   input  logic                i_add,
   input  logic                i_sub,
   input  logic                i_mul,
   input  logic                i_div,
   input  alu_pkg::unit_res_t  i_mul_res,
   input  alu_pkg::unit_res_t  i_div_res,
   output alu_pkg::unit_req_t  o_mul_req,
   output alu_pkg::unit_req_t  o_div_req,
   output alu_pkg::operand_t   o_q,
   output logic                o_ovf,
   output logic                o_accept
);

   // most negative value has no positive magnitude
   localparam alu_pkg::operand_t min_val = {1'b1, {(`ALU_WIDTH-1){1'b0}}};

   logic                busy;
   logic                sign_neg;
   alu_pkg::operand_t   sum;
   alu_pkg::operand_t   diff;
   logic                add_ovf;
   logic                sub_ovf;
   logic                a_neg;
   logic                b_neg;
   logic                mul_rej;
   logic                div_rej;
   alu_pkg::mag_t       mag_a;
   alu_pkg::mag_t       mag_b;
   alu_pkg::unit_res_t  unit_res;

   assign a_neg = i_a[`ALU_WIDTH-1];
   assign b_neg = i_b[`ALU_WIDTH-1];

   // one cycle add / sub with wraparound
   assign sum  = i_a + i_b;
   assign diff = i_a - i_b;
   // same signs in, other sign out
   assign add_ovf = (a_neg == b_neg) && (sum[`ALU_WIDTH-1] != a_neg);
   // differing signs and result flips away from a
   assign sub_ovf = (a_neg != b_neg) && (diff[`ALU_WIDTH-1] != a_neg);

   // rejected before any unit starts
   assign mul_rej = (i_a == min_val) || (i_b == min_val);
   assign div_rej = mul_rej || (i_b == '0);

   // magnitudes fit since min value is rejected
   assign mag_a = a_neg ? alu_pkg::mag_t'(-i_a) : alu_pkg::mag_t'(i_a);
   assign mag_b = b_neg ? alu_pkg::mag_t'(-i_b) : alu_pkg::mag_t'(i_b);

   // only the running unit ever raises done
   assign unit_res = i_mul_res.done ? i_mul_res : i_div_res;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy      <= 1'b0;
         sign_neg  <= 1'b0;
         o_mul_req <= '0;
         o_div_req <= '0;
         o_q       <= '0;
         o_ovf     <= 1'b0;
         o_accept  <= 1'b0;
      end else begin
         // pulses by default
         o_accept        <= 1'b0;
         o_mul_req.start <= 1'b0;
         o_div_req.start <= 1'b0;
         if (!busy) begin
            // priority add, sub, mul, div
            if (i_add) begin
               o_q      <= add_ovf ? '0 : sum;
               o_ovf    <= add_ovf;
               o_accept <= 1'b1;
            end else if (i_sub) begin
               o_q      <= sub_ovf ? '0 : diff;
               o_ovf    <= sub_ovf;
               o_accept <= 1'b1;
            end else if (i_mul) begin
               if (mul_rej) begin
                  o_q      <= '0;
                  o_ovf    <= 1'b1;
                  o_accept <= 1'b1;
               end else begin
                  o_mul_req <= '{start: 1'b1, mag_a: mag_a, mag_b: mag_b};
                  sign_neg  <= a_neg ^ b_neg;
                  busy      <= 1'b1;
               end
            end else if (i_div) begin
               if (div_rej) begin
                  o_q      <= '0;
                  o_ovf    <= 1'b1;
                  o_accept <= 1'b1;
               end else begin
                  o_div_req <= '{start: 1'b1, mag_a: mag_a, mag_b: mag_b};
                  sign_neg  <= a_neg ^ b_neg;
                  busy      <= 1'b1;
               end
            end
         end else if (unit_res.done) begin
            // strobes ignored while a unit runs
            if (unit_res.ovf) begin
               o_q   <= '0;
               o_ovf <= 1'b1;
            end else begin
               // negating zero stays zero
               o_q   <= sign_neg ? -alu_pkg::operand_t'(unit_res.mag_q)
                                 : alu_pkg::operand_t'(unit_res.mag_q);
               o_ovf <= 1'b0;
            end
            o_accept <= 1'b1;
            busy     <= 1'b0;
         end
      end
   end

   // one unit at a time, answering only while launched
   a_one_unit: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (i_mul_res.done || i_div_res.done) |->
         (busy && !(i_mul_res.done && i_div_res.done)));

   // every operation ends in a single pulse
   a_accept_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_accept |=> !o_accept);

endmodule

//--- hdl/alu_pkg.sv
`include "alu_config.svh"

package alu_pkg;

   // signed operand / result word
   typedef logic signed [`ALU_WIDTH-1:0] operand_t;

   // unsigned magnitude of an operand
   typedef logic [`ALU_WIDTH-1:0] mag_t;

   // launch request, control to one unit
   typedef struct packed {
      logic start;
      mag_t mag_a;
      mag_t mag_b;
   } unit_req_t;

   // unit answer back to control
   // ovf and mag_q only valid with done
   typedef struct packed {
      logic done;
      logic ovf;
      mag_t mag_q;
   } unit_res_t;

endpackage

//--- hdl/restoring_divider.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module restoring_divider (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  alu_pkg::unit_req_t  i_req,
   output alu_pkg::unit_res_t  o_res
);

   // index of the final step
   localparam logic [`ALU_CNT_W-1:0] last_step = `ALU_CNT_W'(`ALU_WIDTH - 1);

   logic                       busy;
   logic                       done_r;
   logic [`ALU_CNT_W-1:0]      cnt;
   // dividend shifts out the top, quotient shifts in the bottom
   alu_pkg::mag_t              dq;
   alu_pkg::mag_t              rem;
   alu_pkg::mag_t              dvs;
   alu_pkg::mag_t              src_dq;
   alu_pkg::mag_t              src_rem;
   alu_pkg::mag_t              src_dvs;
   alu_pkg::mag_t              shifted;
   logic [`ALU_WIDTH:0]        trial;
   logic                       fits;

   // first step works straight off the request
   assign src_dq  = i_req.start ? i_req.mag_a : dq;
   assign src_rem = i_req.start ? '0 : rem;
   assign src_dvs = i_req.start ? i_req.mag_b : dvs;

   // remainder stays below divisor, top bit always clear
   assign shifted = {src_rem[`ALU_WIDTH-2:0], src_dq[`ALU_WIDTH-1]};
   assign trial   = {1'b0, shifted} - {1'b0, src_dvs};
   // no borrow, keep the difference
   assign fits    = !trial[`ALU_WIDTH];

   // datapath, one quotient bit per step
   always_ff @(posedge i_clk) begin
      if (i_req.start || busy) begin
         rem <= fits ? trial[`ALU_WIDTH-1:0] : shifted;
         dq  <= {src_dq[`ALU_WIDTH-2:0], fits};
         dvs <= src_dvs;
      end
   end

   // step counter
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy   <= 1'b0;
         done_r <= 1'b0;
         cnt    <= '0;
      end else begin
         done_r <= 1'b0;
         if (i_req.start) begin
            // step zero done on this edge
            busy <= 1'b1;
            cnt  <= `ALU_CNT_W'(1);
         end else if (busy) begin
            if (cnt == last_step) begin
               busy   <= 1'b0;
               done_r <= 1'b1;
               cnt    <= '0;
            end else begin
               cnt <= cnt + 1'b1;
            end
         end
      end
   end

   // zero divisor is caught in control, so no overflow here
   assign o_res = '{done: done_r, ovf: 1'b0, mag_q: dq};

   a_no_restart: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_req.start |-> !busy);

   // control rejects a zero divisor
   a_div_nonzero: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_req.start |-> (i_req.mag_b != '0));

endmodule

//--- hdl/sequential_alu.sv
`timescale 1ns/10ps

module sequential_alu (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  alu_pkg::operand_t  i_a,
   input  alu_pkg::operand_t  i_b,
   input  logic               i_add,
   input  logic               i_sub,
   input  logic               i_mul,
   input  logic               i_div,
   output alu_pkg::operand_t  o_q,
   output logic               o_ovf,
   output logic               o_accept
);

   // requests out to the units
   alu_pkg::unit_req_t  mul_req;
   alu_pkg::unit_req_t  div_req;
   // answers back to control
   alu_pkg::unit_res_t  mul_res;
   alu_pkg::unit_res_t  div_res;

   // decode, add/sub, sign handling, output regs
   alu_control alu_control_i (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_a        (i_a),
      .i_b        (i_b),
      .i_add      (i_add),
      .i_sub      (i_sub),
      .i_mul      (i_mul),
      .i_div      (i_div),
      .i_mul_res  (mul_res),
      .i_div_res  (div_res),
      .o_mul_req  (mul_req),
      .o_div_req  (div_req),
      .o_q        (o_q),
      .o_ovf      (o_ovf),
      .o_accept   (o_accept)
   );

   // unsigned magnitude multiply
   shift_add_multiplier shift_add_multiplier_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_req   (mul_req),
      .o_res   (mul_res)
   );

   // unsigned magnitude divide
   restoring_divider restoring_divider_i (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_req   (div_req),
      .o_res   (div_res)
   );

endmodule

//--- hdl/shift_add_multiplier.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module shift_add_multiplier (
   input  logic                i_clk,
   input  logic                i_nrst,
   input  alu_pkg::unit_req_t  i_req,
   output alu_pkg::unit_res_t  o_res
);

   logic                    busy;
   logic                    done_r;
   logic                    ovf_r;
   alu_pkg::mag_t           acc;
   alu_pkg::mag_t           mcand;
   alu_pkg::mag_t           mplier;
   // one extra bit to see the carry out
   logic [`ALU_WIDTH:0]     sum;
   logic                    range_err;

   // add shifted multiplicand on a set low bit
   assign sum = {1'b0, acc} + (mplier[0] ? {1'b0, mcand} : '0);

   // sum above 2^(W-1)-1, or multiplicand already too big
   // while multiplier bits remain
   assign range_err = mcand[`ALU_WIDTH-1] || (sum[`ALU_WIDTH:`ALU_WIDTH-1] != 2'b00);

   // datapath
   always_ff @(posedge i_clk) begin
      if (i_req.start) begin
         acc    <= '0;
         mcand  <= i_req.mag_a;
         mplier <= i_req.mag_b;
      end else if (busy) begin
         acc    <= sum[`ALU_WIDTH-1:0];
         mcand  <= mcand << 1;
         mplier <= mplier >> 1;
      end
   end

   // run control
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         busy   <= 1'b0;
         done_r <= 1'b0;
         ovf_r  <= 1'b0;
      end else begin
         done_r <= 1'b0;
         if (i_req.start) begin
            busy  <= 1'b1;
            ovf_r <= 1'b0;
         end else if (busy) begin
            if (mplier == '0) begin
               // nothing left to add
               busy   <= 1'b0;
               done_r <= 1'b1;
               ovf_r  <= 1'b0;
            end else if (range_err) begin
               // early exit
               busy   <= 1'b0;
               done_r <= 1'b1;
               ovf_r  <= 1'b1;
            end
         end
      end
   end

   assign o_res = '{done: done_r, ovf: ovf_r, mag_q: acc};

   // control holds off until accept
   a_no_restart: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_req.start |-> !busy);

endmodule

//--- sources.f
+incdir+hdl
hdl/alu_pkg.sv
hdl/alu_control.sv
hdl/shift_add_multiplier.sv
hdl/restoring_divider.sv
hdl/sequential_alu.sv
tb/tb_sequential_alu.sv

//--- tb/tb_sequential_alu.sv
`timescale 1ns/10ps
`include "alu_config.svh"

module tb_sequential_alu;

   localparam int w = `ALU_WIDTH;
   localparam int reset_cycles = 5;
   // longest wait for one accept as divide takes about w+2
   localparam int accept_limit = w + 4;
   localparam int random_rows = 40;
   localparam int min_val = -(2 ** (w - 1));
   localparam int max_val = 2 ** (w - 1) - 1;

   localparam logic [1:0] cmd_add = 2'd0;
   localparam logic [1:0] cmd_sub = 2'd1;
   localparam logic [1:0] cmd_mul = 2'd2;
   localparam logic [1:0] cmd_div = 2'd3;

   // one stimulus row with its expected answer
   typedef struct packed {
      logic [1:0]         cmd;
      logic               poke;
      logic               fast;
      alu_pkg::operand_t  a;
      alu_pkg::operand_t  b;
      alu_pkg::operand_t  exp_q;
      logic               exp_ovf;
   } row_t;

   logic               i_clk;
   logic               i_nrst;
   alu_pkg::operand_t  i_a;
   alu_pkg::operand_t  i_b;
   logic               i_add;
   logic               i_sub;
   logic               i_mul;
   logic               i_div;
   alu_pkg::operand_t  o_q;
   logic               o_ovf;
   logic               o_accept;

   int           errors = 0;
   int           cycles = 0;
   int           cycle_limit;
   logic [31:0]  rng_state;
   row_t         rows[$];

   sequential_alu sequential_alu_i (
      .i_clk    (i_clk),
      .i_nrst   (i_nrst),
      .i_a      (i_a),
      .i_b      (i_b),
      .i_add    (i_add),
      .i_sub    (i_sub),
      .i_mul    (i_mul),
      .i_div    (i_div),
      .o_q      (o_q),
      .o_ovf    (o_ovf),
      .o_accept (o_accept)
   );

   // 8 ns period
   always #4 i_clk = ~i_clk;

   // run limit as the worst row needs about w+8 cycles
   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: simulation ran past %0d cycles", cycle_limit);
         $display("Something failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // expected result straight from the arithmetic rules
   function automatic row_t make_row(input logic [1:0] cmd, input alu_pkg::operand_t a,
                                     input alu_pkg::operand_t b, input logic poke);
      row_t row;
      int   sa;
      int   sb;
      int   r;
      logic ovf;
      sa  = int'(a);
      sb  = int'(b);
      r   = 0;
      ovf = 1'b0;
      row.fast = 1'b0;
      case (cmd)
         cmd_add: begin
            r   = sa + sb;
            ovf = (r > max_val) || (r < min_val);
            row.fast = 1'b1;
         end
         cmd_sub: begin
            r   = sa - sb;
            ovf = (r > max_val) || (r < min_val);
            row.fast = 1'b1;
         end
         cmd_mul: begin
            // most negative operand never reaches the loop
            row.fast = (sa == min_val) || (sb == min_val);
            r   = sa * sb;
            ovf = row.fast || (r > max_val) || (r < -max_val);
         end
         default: begin
            row.fast = (sb == 0) || (sa == min_val) || (sb == min_val);
            ovf = row.fast;
            // int division truncates toward zero
            if (!ovf)
               r = sa / sb;
         end
      endcase
      row.cmd     = cmd;
      row.poke    = poke;
      row.a       = a;
      row.b       = b;
      row.exp_ovf = ovf;
      row.exp_q   = ovf ? '0 : alu_pkg::operand_t'(r);
      return row;
   endfunction

   task automatic add_row(input logic [1:0] cmd, input int a, input int b, input logic poke);
      rows.push_back(make_row(cmd, alu_pkg::operand_t'(a), alu_pkg::operand_t'(b), poke));
   endtask

   task automatic build_table();
      logic [31:0]        ra;
      logic [31:0]        rb;
      logic [1:0]         cmd;
      alu_pkg::operand_t  a;
      alu_pkg::operand_t  b;
      // add / sub edges incl max+1 and min-1
      add_row(cmd_add, max_val, 1, 1'b0);
      add_row(cmd_add, min_val, -1, 1'b0);
      add_row(cmd_add, 100, -200, 1'b0);
      add_row(cmd_add, -5, -7, 1'b0);
      add_row(cmd_sub, min_val, 1, 1'b0);
      add_row(cmd_sub, max_val, -1, 1'b0);
      add_row(cmd_sub, 5, 9, 1'b0);
      add_row(cmd_sub, min_val, min_val, 1'b0);
      // multiply signs, zeros, range limits
      add_row(cmd_mul, 7, -9, 1'b0);
      add_row(cmd_mul, -12, -11, 1'b0);
      add_row(cmd_mul, -3, 0, 1'b0);
      add_row(cmd_mul, 0, 5, 1'b0);
      add_row(cmd_mul, 1, 1, 1'b0);
      add_row(cmd_mul, 181, 181, 1'b0);
      add_row(cmd_mul, 256, 128, 1'b0);
      add_row(cmd_mul, -256, 128, 1'b0);
      add_row(cmd_mul, 300, 300, 1'b0);
      // multiplicand shifted past the top before it is added
      add_row(cmd_mul, 16384, 4, 1'b0);
      add_row(cmd_mul, min_val, 1, 1'b0);
      // divide signs and truncation
      add_row(cmd_div, 100, 7, 1'b0);
      add_row(cmd_div, -100, 7, 1'b0);
      add_row(cmd_div, 100, -7, 1'b0);
      add_row(cmd_div, -100, -7, 1'b0);
      add_row(cmd_div, 3, 10, 1'b0);
      add_row(cmd_div, -3, 10, 1'b0);
      add_row(cmd_div, max_val, 1, 1'b0);
      // rejected divides
      add_row(cmd_div, 5, 0, 1'b0);
      add_row(cmd_div, min_val, 3, 1'b0);
      add_row(cmd_div, 7, min_val, 1'b0);
      // second strobe while a unit runs
      add_row(cmd_mul, 123, 45, 1'b1);
      add_row(cmd_div, -1000, 3, 1'b1);
      for (int i = 0; i < random_rows; i++) begin
         rng_state = xorshift32(rng_state);
         ra = rng_state;
         rng_state = xorshift32(rng_state);
         rb = rng_state;
         cmd = ra[1:0];
         a = ra[31:16];
         b = rb[31:16];
         // shrink operands so products sometimes fit
         if (cmd == cmd_mul) begin
            a = a >>> 6;
            b = b >>> 8;
         end else if (cmd == cmd_div) begin
            b = b >>> 8;
         end
         rows.push_back(make_row(cmd, a, b, 1'b0));
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error: %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   task automatic drive_strobe(input logic [1:0] cmd);
      case (cmd)
         cmd_add: i_add <= 1'b1;
         cmd_sub: i_sub <= 1'b1;
         cmd_mul: i_mul <= 1'b1;
         default: i_div <= 1'b1;
      endcase
   endtask

   task automatic clear_strobes();
      i_add <= 1'b0;
      i_sub <= 1'b0;
      i_mul <= 1'b0;
      i_div <= 1'b0;
   endtask

   task automatic apply_row(input int idx);
      row_t row;
      int   lat;
      logic got;
      row = rows[idx];
      lat = 0;
      got = 1'b0;
      @(posedge i_clk);
      i_a <= row.a;
      i_b <= row.b;
      drive_strobe(row.cmd);
      while (!got && lat < accept_limit) begin
         @(posedge i_clk);
         clear_strobes();
         // extra add while busy must be dropped
         if (row.poke && lat == 0)
            i_add <= 1'b1;
         @(negedge i_clk);
         lat++;
         got = o_accept;
      end
      if (!got) begin
         $display("row %0d: no accept within %0d cycles of the strobe", idx, accept_limit);
         errors++;
      end else begin
         check_val($sformatf("row %0d o_q", idx), 32'(o_q), 32'(row.exp_q));
         check_val($sformatf("row %0d o_ovf", idx), 32'(o_ovf), 32'(row.exp_ovf));
         if (row.fast)
            check_val($sformatf("row %0d accept latency", idx), 32'(lat), 32'd1);
      end
      // a single accept per command
      repeat (3) begin
         @(posedge i_clk);
         clear_strobes();
         @(negedge i_clk);
         if (o_accept) begin
            $display("row %0d: a second accept followed the result", idx);
            errors++;
         end
      end
   endtask

   initial begin
      i_clk  = 1'b0;
      i_nrst = 1'b0;
      i_a    = '0;
      i_b    = '0;
      i_add  = 1'b0;
      i_sub  = 1'b0;
      i_mul  = 1'b0;
      i_div  = 1'b0;
      rng_state = 32'h0272f1ab;
      build_table();
      cycle_limit = rows.size() * (w + 8) + reset_cycles;
      repeat (reset_cycles) @(posedge i_clk);
      i_nrst <= 1'b1;
      // idle outputs before any strobe
      @(negedge i_clk);
      check_val("o_accept after reset", 32'(o_accept), 32'd0);
      check_val("o_q after reset", 32'(o_q), 32'd0);
      check_val("o_ovf after reset", 32'(o_ovf), 32'd0);
      for (int i = 0; i < rows.size(); i++)
         apply_row(i);
      $display("finished %0d rows with %0d errors", rows.size(), errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule
